// File: compile.f
+incdir+rtl
rtl/apb_bridge_pkg.sv
rtl/apb_sync_fifo.sv
rtl/apb_master_fsm.sv
rtl/apb_slave_mux.sv
rtl/apb_bridge_top.sv
verification/apb_periph_model.sv
verification/tb_apb_bridge.sv

// File: rtl/apb_bridge_pkg.sv
`include "apb_bridge_settings.svh"

package apb_bridge_pkg;

    // one queued write
    typedef struct packed {
        logic [`APB_DW-1:0] addr;
        logic [`APB_DW-1:0] data;
    } wr_req_t;

    // one read result for the host
    typedef struct packed {
        logic [`APB_DW-1:0] data;
        logic               err;
    } rd_rsp_t;

    typedef struct packed {
        logic [`APB_DW-`APB_REGION_LSB-`APB_REGION_W-1:0] upper;
        logic [`APB_REGION_W-1:0]                         region;
        logic [`APB_REGION_LSB-1:0]                       offset;
    } apb_addr_fields_t;

    // address word, raw or split into fields
    typedef union packed {
        logic [`APB_DW-1:0] raw;
        apb_addr_fields_t   f;
    } apb_addr_u;

    typedef struct packed {
        logic               pready;
        logic               pslverr;
        logic [`APB_DW-1:0] prdata;
    } apb_slv_rsp_t;

endpackage

// File: rtl/apb_bridge_settings.svh
`ifndef APB_BRIDGE_SETTINGS_SVH
`define APB_BRIDGE_SETTINGS_SVH

// bus data and address width
`define APB_DW 32

// peripheral slots on the bus
`define APB_PD_NUM 3

// entries per FIFO
`define APB_FIFO_DEPTH 4

// region field sits at paddr[13:12]
`define APB_REGION_LSB 12
`define APB_REGION_W 2

`endif

// File: rtl/apb_bridge_top.sv
`timescale 1ns/1ps
`include "apb_bridge_settings.svh"

module apb_bridge_top
    import apb_bridge_pkg::*;
(
    input  logic                   pclk,
    input  logic                   prstn,
    input  logic                   wr_push,
    input  wr_req_t                wr_req,
    input  logic                   rd_push,
    input  logic [`APB_DW-1:0]     rd_addr,
    input  logic                   rd_pop,
    input  apb_slv_rsp_t           slv_rsp [`APB_PD_NUM],
    output logic                   wr_full,
    output logic                   rd_full,
    output rd_rsp_t                rd_rsp,
    output logic                   rd_empty,
    output logic [`APB_DW-1:0]     paddr,
    output logic [`APB_PD_NUM-1:0] pselx,
    output logic                   penable,
    output logic                   pwrite,
    output logic [`APB_DW-1:0]     pwdata,
    output logic                   done,
    output logic                   resp
);

    wr_req_t            wr_head;
    logic               wr_empty;
    logic               wbuffread;
    logic [`APB_DW-1:0] ra_head;
    logic               ra_empty;
    logic               rbuffread;
    logic               rbuffwrite;
    rd_rsp_t            rbuffdata;
    logic               rdata_full;
    apb_addr_u          bus_addr;
    logic               psel;
    apb_slv_rsp_t       bus_rsp;

    assign paddr = bus_addr.raw;

    apb_sync_fifo #(.WIDTH($bits(wr_req_t))) u_wr_fifo (
        .pclk  (pclk),
        .prstn (prstn),
        .push  (wr_push),
        .din   (wr_req),
        .pop   (wbuffread),
        .dout  (wr_head),
        .empty (wr_empty),
        .full  (wr_full)
    );

    apb_sync_fifo #(.WIDTH(`APB_DW)) u_raddr_fifo (
        .pclk  (pclk),
        .prstn (prstn),
        .push  (rd_push),
        .din   (rd_addr),
        .pop   (rbuffread),
        .dout  (ra_head),
        .empty (ra_empty),
        .full  (rd_full)
    );

    // results wait here until the host pops them
    apb_sync_fifo #(.WIDTH($bits(rd_rsp_t))) u_rdata_fifo (
        .pclk  (pclk),
        .prstn (prstn),
        .push  (rbuffwrite),
        .din   (rbuffdata),
        .pop   (rd_pop),
        .dout  (rd_rsp),
        .empty (rd_empty),
        .full  (rdata_full)
    );

    apb_master_fsm u_master (
        .pclk         (pclk),
        .prstn        (prstn),
        .wreq         (!wr_empty),
        .wr_head      (wr_head),
        .rreq         (!ra_empty),
        .rd_addr_head (ra_head),
        .rd_space     (!rdata_full),
        .bus_rsp      (bus_rsp),
        .wbuffread    (wbuffread),
        .rbuffread    (rbuffread),
        .rbuffwrite   (rbuffwrite),
        .rbuffdata    (rbuffdata),
        .paddr        (bus_addr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .done         (done),
        .resp         (resp)
    );

    apb_slave_mux u_mux (
        .paddr   (bus_addr),
        .psel    (psel),
        .slv_rsp (slv_rsp),
        .pselx   (pselx),
        .bus_rsp (bus_rsp)
    );

endmodule

// File: rtl/apb_master_fsm.sv
`timescale 1ns/1ps
`include "apb_bridge_settings.svh"

module apb_master_fsm
    import apb_bridge_pkg::*;
(
    input  logic               pclk,
    input  logic               prstn,
    input  logic               wreq,
    input  wr_req_t            wr_head,
    input  logic               rreq,
    input  logic [`APB_DW-1:0] rd_addr_head,
    input  logic               rd_space,
    input  apb_slv_rsp_t       bus_rsp,
    output logic               wbuffread,
    output logic               rbuffread,
    output logic               rbuffwrite,
    output rd_rsp_t            rbuffdata,
    output apb_addr_u          paddr,
    output logic               psel,
    output logic               penable,
    output logic               pwrite,
    output logic [`APB_DW-1:0] pwdata,
    output logic               done,
    output logic               resp
);

    localparam logic [1:0] IDLE   = 2'd0;
    localparam logic [1:0] SETUP  = 2'd1;
    localparam logic [1:0] ACCESS = 2'd2;

    logic [1:0] state;
    logic [1:0] nextstate;
    logic       complete;
    logic       rd_go;

    assign complete = (state == ACCESS) && bus_rsp.pready;

    // a read finishing this cycle may take the last free result slot
    assign rd_go = rreq && rd_space && !(complete && !pwrite);

    always_ff @(posedge pclk) begin
        if (!prstn) begin
            state <= IDLE;
        end else begin
            state <= nextstate;
        end
    end

    // writes win when both queues hold work
    always_comb begin
        case (state)
            IDLE: begin
                if (wreq || rd_go) begin
                    nextstate = SETUP;
                end else begin
                    nextstate = IDLE;
                end
            end
            SETUP: begin
                nextstate = ACCESS;
            end
            ACCESS: begin
                if (!bus_rsp.pready) begin
                    nextstate = ACCESS;
                end else if (wreq || rd_go) begin
                    nextstate = SETUP;
                end else begin
                    nextstate = IDLE;
                end
            end
            default: begin
                nextstate = IDLE;
            end
        endcase
    end

    // bus control, registered from nextstate
    always_ff @(posedge pclk) begin
        if (!prstn) begin
            psel      <= 1'b0;
            penable   <= 1'b0;
            pwrite    <= 1'b0;
            wbuffread <= 1'b0;
            rbuffread <= 1'b0;
        end else begin
            wbuffread <= 1'b0;
            rbuffread <= 1'b0;
            case (nextstate)
                SETUP: begin
                    psel    <= 1'b1;
                    penable <= 1'b0;
                    pwrite  <= wreq;
                    if (wreq) begin
                        wbuffread <= 1'b1;
                    end else begin
                        rbuffread <= 1'b1;
                    end
                end
                ACCESS: begin
                    penable <= 1'b1;
                end
                default: begin
                    psel    <= 1'b0;
                    penable <= 1'b0;
                    pwrite  <= 1'b0;
                end
            endcase
        end
    end

    // address and write data latch on entry to SETUP
    always_ff @(posedge pclk) begin
        if (nextstate == SETUP) begin
            if (wreq) begin
                paddr.raw <= wr_head.addr;
                pwdata    <= wr_head.data;
            end else begin
                paddr.raw <= rd_addr_head;
                pwdata    <= '0;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (!prstn) begin
            done <= 1'b0;
            resp <= 1'b0;
        end else begin
            done <= complete;
            resp <= complete && bus_rsp.pslverr;
        end
    end

    // read result goes straight into the result FIFO on the completing edge
    assign rbuffwrite     = complete && !pwrite;
    assign rbuffdata.data = bus_rsp.prdata;
    assign rbuffdata.err  = bus_rsp.pslverr;

endmodule

// File: rtl/apb_slave_mux.sv
`timescale 1ns/1ps
`include "apb_bridge_settings.svh"

module apb_slave_mux
    import apb_bridge_pkg::*;
(
    input  apb_addr_u                paddr,
    input  logic                     psel,
    input  apb_slv_rsp_t             slv_rsp [`APB_PD_NUM],
    output logic [`APB_PD_NUM-1:0]   pselx,
    output apb_slv_rsp_t             bus_rsp
);

    logic [`APB_REGION_W-1:0] region;
    logic                     mapped;

    assign region = paddr.f.region;
    assign mapped = (region < `APB_REGION_W'(`APB_PD_NUM));

    always_comb begin
        pselx   = '0;
        bus_rsp = '0;
        if (psel) begin
            if (mapped) begin
                pselx[region] = 1'b1;
                bus_rsp       = slv_rsp[region];
            end else begin
                // unmapped region answers at once with an error
                bus_rsp.pready  = 1'b1;
                bus_rsp.pslverr = 1'b1;
                bus_rsp.prdata  = '0;
            end
        end
    end

endmodule

// File: rtl/apb_sync_fifo.sv
`timescale 1ns/1ps
`include "apb_bridge_settings.svh"

module apb_sync_fifo #(
    parameter int WIDTH = 32
) (
    input  logic             pclk,
    input  logic             prstn,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full
);

    localparam int DEPTH = `APB_FIFO_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));

    // a pop frees the slot a full-FIFO push needs
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    // head shows without a read cycle
    assign dout = mem[rd_ptr];

    always_ff @(posedge pclk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge pclk) begin
        if (!prstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_apb_bridge --Mdir obj_dir

out=$(./obj_dir/Vtb_apb_bridge)
echo "$out"

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
else
    exit 1
fi

// File: verification/apb_periph_model.sv
`timescale 1ns/1ps
`include "apb_bridge_settings.svh"

module apb_periph_model
    import apb_bridge_pkg::*;
(
    input  logic               pclk,
    input  logic               prstn,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`APB_DW-1:0] paddr,
    input  logic [`APB_DW-1:0] pwdata,
    input  logic [3:0]         waits,
    output apb_slv_rsp_t       rsp
);

    logic [`APB_DW-1:0] regs [16];
    logic [3:0]         cnt;
    logic [3:0]         idx;

    assign idx = paddr[5:2];

    // ready once the access phase has waited the set number of cycles
    assign rsp.pready  = psel && penable && (cnt == waits);
    assign rsp.pslverr = 1'b0;
    assign rsp.prdata  = regs[idx];

    always_ff @(posedge pclk) begin
        if (!prstn) begin
            cnt <= '0;
        end else if (psel && penable && !rsp.pready) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    always_ff @(posedge pclk) begin
        if (psel && penable && rsp.pready && pwrite) begin
            regs[idx] <= pwdata;
        end
    end

endmodule

// File: verification/tb_apb_bridge.sv
`timescale 1ns/1ps
`include "apb_bridge_settings.svh"

module tb_apb_bridge
    import apb_bridge_pkg::*;
();

    localparam int TMO = 100;

    logic                   pclk;
    logic                   prstn;
    logic                   wr_push;
    wr_req_t                wr_req;
    logic                   rd_push;
    logic [`APB_DW-1:0]     rd_addr;
    logic                   rd_pop;
    apb_slv_rsp_t           slv_rsp [`APB_PD_NUM];
    logic                   wr_full;
    logic                   rd_full;
    rd_rsp_t                rd_rsp;
    logic                   rd_empty;
    logic [`APB_DW-1:0]     paddr;
    logic [`APB_PD_NUM-1:0] pselx;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_DW-1:0]     pwdata;
    logic                   done;
    logic                   resp;
    logic [3:0]             waits [`APB_PD_NUM];
    logic [`APB_DW-1:0]     acc_addr;
    logic [`APB_DW-1:0]     acc_wdata;
    int                     errors = 0;
    int                     checks = 0;
    int                     seed = 42;

    apb_bridge_top u_dut (
        .pclk     (pclk),
        .prstn    (prstn),
        .wr_push  (wr_push),
        .wr_req   (wr_req),
        .rd_push  (rd_push),
        .rd_addr  (rd_addr),
        .rd_pop   (rd_pop),
        .slv_rsp  (slv_rsp),
        .wr_full  (wr_full),
        .rd_full  (rd_full),
        .rd_rsp   (rd_rsp),
        .rd_empty (rd_empty),
        .paddr    (paddr),
        .pselx    (pselx),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .done     (done),
        .resp     (resp)
    );

    for (genvar g = 0; g < `APB_PD_NUM; g++) begin : g_periph
        apb_periph_model u_periph (
            .pclk    (pclk),
            .prstn   (prstn),
            .psel    (pselx[g]),
            .penable (penable),
            .pwrite  (pwrite),
            .paddr   (paddr),
            .pwdata  (pwdata),
            .waits   (waits[g]),
            .rsp     (slv_rsp[g])
        );
    end

    initial begin
        pclk = 1'b0;
        forever #2 pclk = ~pclk;
    end

    function automatic logic [`APB_DW-1:0] make_addr(input int region, input int word);
        apb_addr_u a;
        a.raw      = '0;
        a.f.region = 2'(region);
        a.f.offset = 12'(word * 4);
        return a.raw;
    endfunction

    function automatic rd_rsp_t make_rsp(input logic [`APB_DW-1:0] d, input logic e);
        rd_rsp_t r;
        r.data = d;
        r.err  = e;
        return r;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [`APB_DW-1:0] got,
                              input logic [`APB_DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_sel(input string name, input logic [`APB_PD_NUM-1:0] got,
                             input logic [`APB_PD_NUM-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rsp(input rd_rsp_t got, input rd_rsp_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail rd_rsp: got data %h err %h expected data %h err %h",
                     got.data, got.err, exp.data, exp.err);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    task automatic push_write(input logic [`APB_DW-1:0] a, input logic [`APB_DW-1:0] d);
        wr_req.addr = a;
        wr_req.data = d;
        wr_push     = 1'b1;
        @(negedge pclk);
        wr_push = 1'b0;
    endtask

    task automatic push_read(input logic [`APB_DW-1:0] a);
        int i;
        for (i = 0; i < TMO && rd_full; i++) begin
            @(negedge pclk);
        end
        if (rd_full) begin
            $display("read address FIFO stayed full too long");
            errors++;
        end
        rd_addr = a;
        rd_push = 1'b1;
        @(negedge pclk);
        rd_push = 1'b0;
    endtask

    // counts access cycles and collects pselx, paddr and pwdata until done
    task automatic wait_done(output logic r, output int acc,
                             output logic [`APB_PD_NUM-1:0] sel, output logic wr);
        int i;
        r         = 1'b0;
        acc       = 0;
        sel       = '0;
        wr        = 1'b0;
        acc_addr  = 'x;
        acc_wdata = 'x;
        for (i = 0; i < TMO; i++) begin
            @(negedge pclk);
            if (done) begin
                break;
            end
            sel |= pselx;
            if (penable) begin
                acc++;
                wr        = pwrite;
                acc_addr  = paddr;
                acc_wdata = pwdata;
            end
        end
        if (i == TMO) begin
            $display("timed out waiting for done");
            errors++;
        end else begin
            r = resp;
        end
    endtask

    task automatic wait_result(input rd_rsp_t exp);
        int i;
        for (i = 0; i < TMO && rd_empty; i++) begin
            @(negedge pclk);
        end
        if (rd_empty) begin
            $display("timed out waiting for a read result");
            errors++;
        end else begin
            check_rsp(rd_rsp, exp);
            rd_pop = 1'b1;
            @(negedge pclk);
            rd_pop = 1'b0;
        end
    endtask

    task automatic single_write(input logic [`APB_DW-1:0] a, input logic [`APB_DW-1:0] d,
                                input logic exp_resp, output int acc,
                                output logic [`APB_PD_NUM-1:0] sel);
        logic r;
        logic wr;
        push_write(a, d);
        wait_done(r, acc, sel, wr);
        check_bit("resp", r, exp_resp);
        check_word("paddr", acc_addr, a);
        check_word("pwdata", acc_wdata, d);
    endtask

    task automatic single_read(input logic [`APB_DW-1:0] a, input rd_rsp_t exp,
                               output int acc, output logic [`APB_PD_NUM-1:0] sel);
        logic r;
        logic wr;
        push_read(a);
        wait_done(r, acc, sel, wr);
        check_bit("resp", r, exp.err);
        check_word("paddr", acc_addr, a);
        wait_result(exp);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_bit("pselx", |pselx, 1'b0);
        check_bit("penable", penable, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("resp", resp, 1'b0);
        check_bit("rd_empty", rd_empty, 1'b1);
        check_bit("wr_full", wr_full, 1'b0);
        check_bit("rd_full", rd_full, 1'b0);
        report("reset", e0);
    endtask

    task automatic test_slots();
        int                     e0;
        int                     acc;
        logic [`APB_PD_NUM-1:0] sel;
        logic [`APB_DW-1:0]     d;
        e0 = errors;
        for (int s = 0; s < `APB_PD_NUM; s++) begin
            d = $random(seed);
            single_write(make_addr(s, s + 1), d, 1'b0, acc, sel);
            check_sel("pselx", sel, `APB_PD_NUM'(1) << s);
            single_read(make_addr(s, s + 1), make_rsp(d, 1'b0), acc, sel);
            check_sel("pselx", sel, `APB_PD_NUM'(1) << s);
        end
        report("slots", e0);
    endtask

    task automatic test_waits();
        int                     e0;
        int                     acc;
        logic [`APB_PD_NUM-1:0] sel;
        logic [`APB_DW-1:0]     d;
        e0       = errors;
        waits[1] = 4'd3;
        d        = $random(seed);
        single_write(make_addr(1, 5), d, 1'b0, acc, sel);
        // done must drop on the next cycle
        @(negedge pclk);
        check_bit("done", done, 1'b0);
        check_int("access cycles", acc, 4);
        single_read(make_addr(1, 5), make_rsp(d, 1'b0), acc, sel);
        check_int("access cycles", acc, 4);
        waits[1] = 4'd0;
        report("wait_states", e0);
    endtask

    task automatic test_unmapped();
        int                     e0;
        int                     acc;
        logic [`APB_PD_NUM-1:0] sel;
        e0 = errors;
        single_write(make_addr(3, 0), $random(seed), 1'b1, acc, sel);
        check_bit("pselx", |sel, 1'b0);
        single_read(make_addr(3, 0), make_rsp('0, 1'b1), acc, sel);
        check_bit("pselx", |sel, 1'b0);
        report("unmapped", e0);
    endtask

    task automatic test_burst();
        int                 e0;
        logic [`APB_DW-1:0] vals [4];
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            vals[k] = $random(seed);
        end
        fork
            begin
                for (int k = 0; k < 4; k++) begin
                    push_write(make_addr(k % 3, 8 + k), vals[k]);
                end
                for (int k = 0; k < 4; k++) begin
                    push_read(make_addr(k % 3, 8 + k));
                end
            end
            begin
                logic                   r;
                int                     acc;
                logic [`APB_PD_NUM-1:0] sel;
                logic                   wr;
                for (int k = 0; k < 8; k++) begin
                    wait_done(r, acc, sel, wr);
                    check_bit("resp", r, 1'b0);
                    check_bit("pwrite", wr, k < 4);
                end
            end
        join
        for (int k = 0; k < 4; k++) begin
            wait_result(make_rsp(vals[k], 1'b0));
        end
        report("burst", e0);
    endtask

    task automatic test_backpressure();
        int                     e0;
        int                     acc;
        int                     cnt;
        logic [`APB_PD_NUM-1:0] sel;
        logic [`APB_DW-1:0]     vals [6];
        e0  = errors;
        cnt = 0;
        for (int k = 0; k < 6; k++) begin
            vals[k] = $random(seed);
            single_write(make_addr(k % 3, 2 + k), vals[k], 1'b0, acc, sel);
        end
        // results stay unpopped until the result FIFO fills and reads stall
        fork
            begin
                for (int k = 0; k < 6; k++) begin
                    push_read(make_addr(k % 3, 2 + k));
                end
            end
            begin
                for (int i = 0; i < 40; i++) begin
                    @(negedge pclk);
                    if (done) begin
                        cnt++;
                    end
                end
            end
        join
        check_int("reads done", cnt, `APB_FIFO_DEPTH);
        for (int k = 0; k < 6; k++) begin
            wait_result(make_rsp(vals[k], 1'b0));
        end
        report("backpressure", e0);
    endtask

    initial begin
        prstn   = 1'b0;
        wr_push = 1'b0;
        wr_req  = '0;
        rd_push = 1'b0;
        rd_addr = '0;
        rd_pop  = 1'b0;
        for (int s = 0; s < `APB_PD_NUM; s++) begin
            waits[s] = 4'd0;
        end
        repeat (4) @(posedge pclk);
        @(negedge pclk);
        prstn = 1'b1;
        test_reset();
        test_slots();
        test_waits();
        test_unmapped();
        test_burst();
        test_backpressure();
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
